// File: verilog/rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// reservation station sizing

// number of station entries
`define RS_ENTRIES 4

// log2 of entry count
`define RS_IDX_W 2

// age counter, saturates at all ones
`define RS_AGE_W 3

`define RS_TAG_W 4      // physical register tag
`define RS_OP_W 6       // opcode field

// age width has headroom over entry count so the
// distinct-age ordering holds for a full station

`endif

// File: verilog/rs_pkg.sv
`include "rs_cfg.svh"

package rs_pkg;

    // one bit per station entry
    typedef logic [`RS_ENTRIES-1:0] rs_vec_t;

    // entry number
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;

    // per entry age, higher is older
    typedef logic [`RS_AGE_W-1:0] rs_age_t;

    // register tag, used both for dst and src
    typedef logic [`RS_TAG_W-1:0] rs_tag_t;

    // opcode, passed through untouched
    typedef logic [`RS_OP_W-1:0] rs_op_t;

    // tags stand in for operand values,
    // so no data type is needed here

endpackage

// File: verilog/rs_ctrl_if.sv
// control bundle between entry storage and the allocate/issue selector
interface rs_ctrl_if;

    // status from the array
    rs_pkg::rs_vec_t free;       // entry empty
    rs_pkg::rs_vec_t ready;      // valid and both srcs ready
    logic            dispatch;   // qualified dispatch, station not full

    // decisions from the selector
    rs_pkg::rs_vec_t alloc;      // one-hot, lowest free entry
    rs_pkg::rs_vec_t issue;      // one-hot pick or zero
    rs_pkg::rs_idx_t issue_idx;  // index of the pick

    // array side, owns storage and valid bits
    modport array (
        output free,
        output ready,
        output dispatch,
        input  alloc,
        input  issue,
        input  issue_idx
    );

    // selector side, owns the age counters
    modport sel (
        input  free,
        input  ready,
        input  dispatch,
        output alloc,
        output issue,
        output issue_idx
    );

endinterface

// File: verilog/rs_select.sv
`include "rs_cfg.svh"

// allocation and oldest-ready issue picker
// keeps one age counter per entry
module rs_select (
    input  logic          clk_i,
    input  logic          arst_n_i,
    rs_ctrl_if.sel        ctrl
);

    // age per entry
    rs_pkg::rs_age_t age_q [`RS_ENTRIES];

    // allocation scan
    logic            alloc_found;

    // issue scan
    logic            pick_found;
    rs_pkg::rs_age_t best_age;
    rs_pkg::rs_idx_t best_idx;

    // allocate
    // lowest index free entry becomes the dispatch target
    // selector does not look at full, the array qualifies dispatch
    always_comb begin
        alloc_found = 1'b0;
        ctrl.alloc  = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (ctrl.free[i] && !alloc_found) begin
                ctrl.alloc[i] = 1'b1;   // first free one wins
                alloc_found   = 1'b1;
            end
        end
    end

    // age counters
    // free entry sits at zero, so a fresh dispatch starts at zero
    // occupied entries bump on every accepted dispatch
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (ctrl.free[i]) begin
                    age_q[i] <= '0;                     // empty, hold at zero
                end else if (ctrl.dispatch && (age_q[i] != '1)) begin
                    age_q[i] <= age_q[i] + 1'b1;        // someone newer arrived
                end
            end
        end
    end

    // an entry issued this cycle still counts as occupied here,
    // its age is cleared one cycle later once valid drops

    // issue pick
    // highest age among ready entries
    // strict compare so ties fall to the lowest index
    always_comb begin
        pick_found = 1'b0;
        best_age   = '0;
        best_idx   = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (ctrl.ready[i] && (!pick_found || (age_q[i] > best_age))) begin
                pick_found = 1'b1;
                best_age   = age_q[i];
                best_idx   = rs_pkg::rs_idx_t'(i);
            end
        end
    end

    // one-hot from the chosen index
    always_comb begin
        ctrl.issue = '0;
        if (pick_found) begin
            ctrl.issue[best_idx] = 1'b1;
        end
    end

    assign ctrl.issue_idx = best_idx;   // don't care when nothing ready

    // alloc draws from free entries and issue from valid ones,
    // so the two vectors can never overlap in a cycle

endmodule

// File: verilog/rs_entry_array.sv
`include "rs_cfg.svh"

// entry storage for the reservation station
// valid bits, tags, ready bits, wakeup and the issue mux
module rs_entry_array (
    input  logic            clk_i,
    input  logic            arst_n_i,
    rs_ctrl_if.array        ctrl,

    // dispatch side
    input  logic            dispatch_i,
    input  rs_pkg::rs_op_t  op_i,
    input  rs_pkg::rs_tag_t dst_i,
    input  rs_pkg::rs_tag_t src1_i,
    input  logic            src1_rdy_i,
    input  rs_pkg::rs_tag_t src2_i,
    input  logic            src2_rdy_i,

    // result bus
    input  logic            cdb_valid_i,
    input  rs_pkg::rs_tag_t cdb_tag_i,

    // status and issue
    output logic            full_o,
    output logic            issue_valid_o,
    output rs_pkg::rs_op_t  issue_op_o,
    output rs_pkg::rs_tag_t issue_dst_o
);

    // control state
    rs_pkg::rs_vec_t valid_q;

    // payload, written on dispatch only
    rs_pkg::rs_op_t  op_q     [`RS_ENTRIES];
    rs_pkg::rs_tag_t dst_q    [`RS_ENTRIES];
    rs_pkg::rs_tag_t s1_tag_q [`RS_ENTRIES];
    rs_pkg::rs_tag_t s2_tag_q [`RS_ENTRIES];
    rs_pkg::rs_vec_t s1_rdy_q;
    rs_pkg::rs_vec_t s2_rdy_q;

    // broadcast matches
    logic            s1_bypass;     // incoming src1 hit on cdb this cycle
    logic            s2_bypass;
    rs_pkg::rs_vec_t s1_wake;       // stored src1 hit on cdb
    rs_pkg::rs_vec_t s2_wake;

    // status to selector
    assign ctrl.free  = ~valid_q;
    assign ctrl.ready = valid_q & s1_rdy_q & s2_rdy_q;

    // full is a plain level, dispatch while full is dropped
    assign full_o        = &valid_q;
    assign ctrl.dispatch = dispatch_i & ~full_o;

    // dispatch-time bypass
    // a tag broadcast in the same cycle is already produced
    assign s1_bypass = cdb_valid_i && (cdb_tag_i == src1_i);
    assign s2_bypass = cdb_valid_i && (cdb_tag_i == src2_i);

    // tag compare per entry
    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            s1_wake[i] = cdb_valid_i && (s1_tag_q[i] == cdb_tag_i);
            s2_wake[i] = cdb_valid_i && (s2_tag_q[i] == cdb_tag_i);
        end
    end

    // valid bits
    // set on dispatch into the allocated slot, cleared on issue
    // alloc and issue never point at the same entry
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (ctrl.dispatch && ctrl.alloc[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (ctrl.issue[i]) begin
                    valid_q[i] <= 1'b0;     // freed, usable next cycle
                end
            end
        end
    end

    // payload and operand ready bits
    // ready bits only matter while valid is set
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (ctrl.dispatch && ctrl.alloc[i]) begin
                op_q[i]     <= op_i;
                dst_q[i]    <= dst_i;
                s1_tag_q[i] <= src1_i;
                s2_tag_q[i] <= src2_i;
                s1_rdy_q[i] <= src1_rdy_i | s1_bypass;
                s2_rdy_q[i] <= src2_rdy_i | s2_bypass;
            end else begin
                // wakeup, sticky once set
                if (s1_wake[i]) begin
                    s1_rdy_q[i] <= 1'b1;
                end
                if (s2_wake[i]) begin
                    s2_rdy_q[i] <= 1'b1;
                end
            end
        end
    end

    // issue read
    // combinational from registered state, fields are don't care when idle
    assign issue_valid_o = |ctrl.issue;
    assign issue_op_o    = op_q[ctrl.issue_idx];
    assign issue_dst_o   = dst_q[ctrl.issue_idx];

endmodule

// File: verilog/rs_top.sv
`include "rs_cfg.svh"

// four entry reservation station, out-of-order issue
// array holds the entries, select does alloc and age-ordered pick
module rs_top (
    input  logic            clk_i,
    input  logic            arst_n_i,

    // dispatch strobe and instruction fields
    input  logic            dispatch_i,
    input  rs_pkg::rs_op_t  op_i,
    input  rs_pkg::rs_tag_t dst_i,
    input  rs_pkg::rs_tag_t src1_i,
    input  logic            src1_rdy_i,
    input  rs_pkg::rs_tag_t src2_i,
    input  logic            src2_rdy_i,

    // result broadcast
    input  logic            cdb_valid_i,
    input  rs_pkg::rs_tag_t cdb_tag_i,

    // back-pressure for dispatch
    output logic            full_o,

    // issue port, always accepted downstream
    output logic            issue_valid_o,
    output rs_pkg::rs_op_t  issue_op_o,
    output rs_pkg::rs_tag_t issue_dst_o
);

    // alloc/issue control between array and selector
    rs_ctrl_if ctrl_if ();

    rs_entry_array u_array (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ctrl          (ctrl_if.array),
        .dispatch_i    (dispatch_i),
        .op_i          (op_i),
        .dst_i         (dst_i),
        .src1_i        (src1_i),
        .src1_rdy_i    (src1_rdy_i),
        .src2_i        (src2_i),
        .src2_rdy_i    (src2_rdy_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .full_o        (full_o),
        .issue_valid_o (issue_valid_o),
        .issue_op_o    (issue_op_o),
        .issue_dst_o   (issue_dst_o)
    );

    // age counters live here
    rs_select u_select (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ctrl     (ctrl_if.sel)
    );

endmodule

// File: test/rs_sva.sv
`include "rs_cfg.svh"

// control bundle checks, bound into rs_top
module rs_sva (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            full_i,
    input rs_pkg::rs_vec_t alloc_i,
    input rs_pkg::rs_vec_t issue_i
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    // at most one entry leaves per cycle
    issue_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(issue_i))
        else begin
            fail_cnt++;
            $error("issue vector has more than one bit set: %b", issue_i);
        end

    // a free slot always gives exactly one dispatch target
    alloc_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !full_i |-> $onehot(alloc_i))
        else begin
            fail_cnt++;
            $error("alloc vector not one-hot while station has room: %b", alloc_i);
        end

    // leaving entry is never the new target
    no_overlap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (alloc_i & issue_i) == '0)
        else begin
            fail_cnt++;
            $error("same entry allocated and issued: %b", alloc_i & issue_i);
        end

endmodule

bind rs_top rs_sva u_sva (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .full_i   (full_o),
    .alloc_i  (ctrl_if.alloc),
    .issue_i  (ctrl_if.issue)
);

// File: test/rs_tb.sv
`include "rs_cfg.svh"

module rs_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYC  = 8;
    localparam int RAND_CYC   = 300;
    localparam int AGE_MAX    = (1 << `RS_AGE_W) - 1;
    // reset, direct, wakeup, age, bypass, random plus its drain
    localparam int TEST_CYC   = RESET_CYC + 6 + 3 + 7 + 13 + 2 + RAND_CYC + 16;
    localparam int MARGIN_CYC = 100;

    logic            clk_i;
    logic            arst_n_i;
    logic            dispatch_i;
    rs_pkg::rs_op_t  op_i;
    rs_pkg::rs_tag_t dst_i;
    rs_pkg::rs_tag_t src1_i;
    logic            src1_rdy_i;
    rs_pkg::rs_tag_t src2_i;
    logic            src2_rdy_i;
    logic            cdb_valid_i;
    rs_pkg::rs_tag_t cdb_tag_i;
    logic            full_o;
    logic            issue_valid_o;
    rs_pkg::rs_op_t  issue_op_o;
    rs_pkg::rs_tag_t issue_dst_o;

    // model entry, queue keeps dispatch order
    typedef struct packed {
        rs_pkg::rs_op_t  op;
        rs_pkg::rs_tag_t dst;
        rs_pkg::rs_tag_t s1;
        rs_pkg::rs_tag_t s2;
        logic            r1;
        logic            r2;
        rs_pkg::rs_age_t age;   // dispatches seen while waiting
    } entry_t;

    entry_t      model_q [$];
    int unsigned err_cnt = 0;
    int unsigned chk_cnt = 0;

    rs_top u_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .dispatch_i    (dispatch_i),
        .op_i          (op_i),
        .dst_i         (dst_i),
        .src1_i        (src1_i),
        .src1_rdy_i    (src1_rdy_i),
        .src2_i        (src2_i),
        .src2_rdy_i    (src2_rdy_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .full_o        (full_o),
        .issue_valid_o (issue_valid_o),
        .issue_op_o    (issue_op_o),
        .issue_dst_o   (issue_dst_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // watchdog
    initial begin
        #((TEST_CYC + MARGIN_CYC) * CLK_PERIOD);
        $display("timeout: tests did not finish within the cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("FAIL %s got %0h expected %0h", name, got, exp);
        end
    endtask

    // fields only compared while an issue is expected
    task automatic expect_out(input logic full, input logic valid,
                              input rs_pkg::rs_op_t op, input rs_pkg::rs_tag_t dst);
        check_val("full_o", 32'(full_o), 32'(full));
        check_val("issue_valid_o", 32'(issue_valid_o), 32'(valid));
        if (valid && issue_valid_o) begin
            check_val("issue_op_o", 32'(issue_op_o), 32'(op));
            check_val("issue_dst_o", 32'(issue_dst_o), 32'(dst));
        end
    endtask

    // first fully ready entry in dispatch order, -1 if none
    function automatic int oldest_ready();
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].r1 && model_q[i].r2) return i;
        end
        return -1;
    endfunction

    // two waiting entries both saturated would tie on age
    function automatic logic dispatch_risks_tie();
        return model_q.size() >= 2 && int'(model_q[1].age) >= AGE_MAX - 1;
    endfunction

    task automatic compare_model();
        int   pick;
        logic full;
        pick = oldest_ready();
        full = (model_q.size() == `RS_ENTRIES);
        if (pick >= 0) begin
            expect_out(full, 1'b1, model_q[pick].op, model_q[pick].dst);
        end else begin
            expect_out(full, 1'b0, '0, '0);
        end
    endtask

    // state change at the edge, from the inputs held over the edge
    task automatic model_update();
        int     pick;
        logic   accept;
        entry_t e;
        pick   = oldest_ready();
        accept = dispatch_i && (model_q.size() < `RS_ENTRIES);
        for (int i = 0; i < model_q.size(); i++) begin
            e = model_q[i];
            if (cdb_valid_i && (e.s1 == cdb_tag_i)) e.r1 = 1'b1;
            if (cdb_valid_i && (e.s2 == cdb_tag_i)) e.r2 = 1'b1;
            if (accept && (int'(e.age) != AGE_MAX)) e.age = e.age + 1'b1;
            model_q[i] = e;
        end
        if (pick >= 0) model_q.delete(pick);    // execution unit always takes it
        if (accept) begin
            e.op  = op_i;
            e.dst = dst_i;
            e.s1  = src1_i;
            e.s2  = src2_i;
            e.r1  = src1_rdy_i | (cdb_valid_i && (src1_i == cdb_tag_i));
            e.r2  = src2_rdy_i | (cdb_valid_i && (src2_i == cdb_tag_i));
            e.age = '0;
            model_q.push_back(e);
        end
    endtask

    // one cycle, starts and ends 2 units after a rising edge
    task automatic tick();
        @(negedge clk_i);
        compare_model();
        @(posedge clk_i);
        model_update();
        #2;
        dispatch_i  = 1'b0;     // strobes last one cycle
        cdb_valid_i = 1'b0;
    endtask

    task automatic send_instr(input rs_pkg::rs_op_t op, input rs_pkg::rs_tag_t dst,
                              input rs_pkg::rs_tag_t s1, input logic r1,
                              input rs_pkg::rs_tag_t s2, input logic r2);
        dispatch_i = 1'b1;
        op_i       = op;
        dst_i      = dst;
        src1_i     = s1;
        src1_rdy_i = r1;
        src2_i     = s2;
        src2_rdy_i = r2;
    endtask

    task automatic broadcast(input rs_pkg::rs_tag_t tag);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = tag;
    endtask

    task automatic idle_after_reset();
        expect_out(1'b0, 1'b0, '0, '0);
        repeat (6) begin
            tick();
            expect_out(1'b0, 1'b0, '0, '0);     // idle stays idle
        end
    endtask

    task automatic direct_issue();
        send_instr(6'h15, 4'h7, 4'h1, 1'b1, 4'h2, 1'b1);
        expect_out(1'b0, 1'b0, '0, '0);
        tick();
        expect_out(1'b0, 1'b1, 6'h15, 4'h7);    // one cycle after dispatch
        tick();
        expect_out(1'b0, 1'b0, '0, '0);
    endtask

    task automatic wakeup_issue();
        send_instr(6'h2a, 4'hc, 4'h9, 1'b0, 4'h3, 1'b1);
        tick();
        repeat (3) begin
            expect_out(1'b0, 1'b0, '0, '0);     // src1 still waiting
            tick();
        end
        broadcast(4'h9);
        expect_out(1'b0, 1'b0, '0, '0);
        tick();
        expect_out(1'b0, 1'b1, 6'h2a, 4'hc);
        tick();
        expect_out(1'b0, 1'b0, '0, '0);
    endtask

    task automatic age_order();
        // ready op holds entry 0 for one cycle so the waiters land in 1 0 2 3
        send_instr(6'h01, 4'he, 4'h0, 1'b1, 4'h0, 1'b1);
        tick();
        expect_out(1'b0, 1'b1, 6'h01, 4'he);
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            send_instr(rs_pkg::rs_op_t'(6'h30 + i), rs_pkg::rs_tag_t'(i),
                       4'h5, 1'b0, 4'h6, 1'b1);
            tick();
        end
        expect_out(1'b1, 1'b0, '0, '0);
        send_instr(6'h3f, 4'hf, 4'h0, 1'b1, 4'h0, 1'b1);   // strobe while full
        tick();
        expect_out(1'b1, 1'b0, '0, '0);
        broadcast(4'h5);    // wakes all four
        tick();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            expect_out(i == 0, 1'b1, rs_pkg::rs_op_t'(6'h30 + i), rs_pkg::rs_tag_t'(i));
            tick();
        end
        expect_out(1'b0, 1'b0, '0, '0);
        tick();
        expect_out(1'b0, 1'b0, '0, '0);     // ignored strobe never shows up
    endtask

    task automatic dispatch_bypass();
        send_instr(6'h09, 4'h4, 4'ha, 1'b0, 4'ha, 1'b0);
        broadcast(4'ha);    // same cycle as dispatch
        tick();
        expect_out(1'b0, 1'b1, 6'h09, 4'h4);
        tick();
    endtask

    task automatic random_mix();
        for (int n = 0; n < RAND_CYC; n++) begin
            if (($urandom_range(1, 0) == 1) && !dispatch_risks_tie()) begin
                send_instr(rs_pkg::rs_op_t'($urandom), rs_pkg::rs_tag_t'($urandom),
                           rs_pkg::rs_tag_t'($urandom_range(7, 0)),
                           ($urandom_range(3, 0) != 0),
                           rs_pkg::rs_tag_t'($urandom_range(7, 0)),
                           ($urandom_range(3, 0) != 0));
            end
            if ($urandom_range(1, 0) == 1) begin
                broadcast(rs_pkg::rs_tag_t'($urandom_range(7, 0)));
            end
            tick();     // model compared every cycle
        end
        // drain, every source tag in use gets broadcast
        for (int t = 0; t < 8; t++) begin
            broadcast(rs_pkg::rs_tag_t'(t));
            tick();
        end
        for (int n = 0; (n < 8) && (model_q.size() > 0); n++) begin
            tick();
        end
        expect_out(1'b0, 1'b0, '0, '0);
    endtask

    initial begin
        void'($urandom(32'h0164cf7a));
        arst_n_i    = 1'b0;
        dispatch_i  = 1'b0;
        op_i        = '0;
        dst_i       = '0;
        src1_i      = '0;
        src1_rdy_i  = 1'b0;
        src2_i      = '0;
        src2_rdy_i  = 1'b0;
        cdb_valid_i = 1'b0;
        cdb_tag_i   = '0;
        repeat (RESET_CYC) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        idle_after_reset();
        direct_issue();
        wakeup_issue();
        age_order();
        dispatch_bypass();
        random_mix();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, u_dut.u_sva.fail_cnt);
        if ((err_cnt == 0) && (u_dut.u_sva.fail_cnt == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/rs_pkg.sv
verilog/rs_ctrl_if.sv
verilog/rs_select.sv
verilog/rs_entry_array.sv
verilog/rs_top.sv
test/rs_sva.sv
test/rs_tb.sv

// File: Makefile
SIM = obj_dir/Vrs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module rs_tb -f list.f

run: compile
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir
